//--- include/aiGame_defines.svh
`ifndef AIGAME_DEFINES_SVH
`define AIGAME_DEFINES_SVH

// Serial timing
// Clock cycles per UART bit, kept short for simulation
`define CLKS_PER_BIT 8

// Host command bytes (ASCII)
`define CMD_BOARD 8'h42	// 'B' followed by 8 board bytes
`define CMD_COLOR 8'h43	// 'C' followed by 1 colour byte
`define CMD_MOVES 8'h4D	// 'M' followed by 2 move count bytes
`define CMD_GO    8'h47	// 'G' starts a search

// Reply frame
// Eight board bytes, MSB first, then the status byte
`define REPLY_BYTES 9

`endif

//--- hdl/aiGamePkg.sv
package aiGamePkg;

	// Engine input, written by the command decoder
	typedef struct packed {
		logic [63:0] board;		// 1 = occupied
		logic        color;		// 0 scans upward, 1 downward
		logic [15:0] moveCount;	// Low 6 bits give start cell
	} aiJob_t;

	// Engine output
	// Board comes back with the claimed cell set
	typedef struct packed {
		logic [63:0] board;		// Updated board
		logic        found;		// Empty cell was claimed
		logic [5:0]  cellIdx;	// Claimed cell, 0 when nothing found
	} aiResult_t;

	// Eight active-low segment patterns
	// Index 7 is the leftmost digit, bit 0 of each is segment a
	typedef logic [7:0][6:0] segDigits_t;

endpackage

//--- hdl/uartRx.sv
`timescale 1ns/1ps
`include "aiGame_defines.svh"

module uartRx (
	input  logic       iCLK,
	input  logic       arstN,
	input  logic       rxd,		// Serial line, idles high
	output logic [7:0] rxData,	// Valid with rxValid
	output logic       rxValid	// One-cycle strobe per good frame
);
	localparam int ClksPerBit = `CLKS_PER_BIT;
	localparam int CntW = (ClksPerBit > 1) ? $clog2(ClksPerBit) : 1;
	localparam logic [CntW-1:0] BitLast = CntW'(ClksPerBit - 1);
	localparam logic [CntW-1:0] HalfLast = CntW'(ClksPerBit / 2 - 1);

	typedef enum logic [1:0] {RxIdle, RxStart, RxData, RxStop} rxState_t;

	rxState_t state;
	logic [2:0] rxSync;		// [0],[1] synchroniser, [2] edge history
	logic rxIn;
	logic [CntW-1:0] clkCnt;
	logic [2:0] bitCnt;
	logic [7:0] shiftReg;

	assign rxIn = rxSync[1];
	assign rxData = shiftReg;	// Holds until the next frame's data bits

	always_ff @(posedge iCLK or negedge arstN) begin
		if (!arstN) begin
			rxSync <= '1;	// Line idle
			state <= RxIdle;
			clkCnt <= '0;
			bitCnt <= '0;
			rxValid <= 1'b0;
		end else begin
			rxSync <= {rxSync[1:0], rxd};
			rxValid <= 1'b0;
			case (state)
				RxIdle: begin
					clkCnt <= '0;
					if (rxSync[2] && !rxIn)	// Falling edge of start bit
						state <= RxStart;
				end
				RxStart: begin
					if (clkCnt == HalfLast) begin
						clkCnt <= '0;
						bitCnt <= '0;
						state <= rxIn ? RxIdle : RxData;	// Glitch, not a start bit
					end else
						clkCnt <= clkCnt + 1'b1;
				end
				RxData: begin
					if (clkCnt == BitLast) begin
						clkCnt <= '0;
						bitCnt <= bitCnt + 3'd1;
						if (bitCnt == 3'd7)
							state <= RxStop;
					end else
						clkCnt <= clkCnt + 1'b1;
				end
				default: begin	// RxStop
					if (clkCnt == BitLast) begin
						rxValid <= rxIn;	// Framing error gives no strobe
						state <= RxIdle;
					end else
						clkCnt <= clkCnt + 1'b1;
				end
			endcase
		end
	end

	// Data bits arrive LSB first
	always_ff @(posedge iCLK) begin
		if (state == RxData && clkCnt == BitLast)
			shiftReg <= {rxIn, shiftReg[7:1]};
	end

endmodule

//--- hdl/uartTx.sv
`timescale 1ns/1ps
`include "aiGame_defines.svh"

module uartTx (
	input  logic       iCLK,
	input  logic       arstN,
	input  logic       txStart,	// Accepted only while idle
	input  logic [7:0] txData,
	output logic       txd,		// Serial line, idles high
	output logic       txBusy	// High for the whole frame
);
	localparam int ClksPerBit = `CLKS_PER_BIT;
	localparam int CntW = (ClksPerBit > 1) ? $clog2(ClksPerBit) : 1;
	localparam logic [CntW-1:0] BitLast = CntW'(ClksPerBit - 1);

	logic [9:0] frame;		// Stop, data, start; bit 0 is on the line
	logic [CntW-1:0] clkCnt;
	logic [3:0] bitCnt;		// 0 start .. 9 stop

	assign txd = frame[0];

	always_ff @(posedge iCLK or negedge arstN) begin
		if (!arstN) begin
			frame <= '1;
			txBusy <= 1'b0;
			clkCnt <= '0;
			bitCnt <= '0;
		end else if (!txBusy) begin
			if (txStart) begin
				frame <= {1'b1, txData, 1'b0};	// Start bit goes out next cycle
				txBusy <= 1'b1;
				clkCnt <= '0;
				bitCnt <= '0;
			end
		end else if (clkCnt == BitLast) begin
			clkCnt <= '0;
			frame <= {1'b1, frame[9:1]};	// Ones fill in behind, line ends high
			if (bitCnt == 4'd9)
				txBusy <= 1'b0;	// End of stop bit
			else
				bitCnt <= bitCnt + 4'd1;
		end else begin
			clkCnt <= clkCnt + 1'b1;
		end
	end

endmodule

//--- hdl/cmdDecode.sv
`timescale 1ns/1ps
`include "aiGame_defines.svh"

module cmdDecode (
	input  logic                 iCLK,
	input  logic                 arstN,
	// UART receive side
	input  logic [7:0]           rxData,
	input  logic                 rxValid,
	// UART transmit side
	output logic [7:0]           txData,
	output logic                 txStart,
	input  logic                 txBusy,
	// Engine, four-phase requester
	output aiGamePkg::aiJob_t    job,
	output logic                 aiReq,
	input  logic                 aiAck,
	input  aiGamePkg::aiResult_t aiResult,	// Engine output, stable under aiAck
	output aiGamePkg::aiResult_t result		// Last captured result
);
	localparam logic [3:0] ReplyEnd = 4'(`REPLY_BYTES);

	typedef enum logic [1:0] {DecIdle, DecArgs, DecWait, DecReply} decState_t;
	typedef enum logic [1:0] {ArgBoard, ArgColor, ArgMoves} argSel_t;

	decState_t state;
	argSel_t argSel;		// Field the argument bytes go to
	logic [2:0] argCnt;		// Argument bytes left minus one
	logic [3:0] byteIdx;	// Next reply byte
	logic [7:0][7:0] boardBytes;
	logic [7:0] replyByte;
	logic issue;

	assign boardBytes = result.board;

	// Send next byte once the transmitter is free
	// txStart guard covers the cycle before txBusy rises
	assign issue = (state == DecReply) && !txBusy && !txStart && (byteIdx != ReplyEnd);

	always_comb begin
		if (byteIdx < ReplyEnd - 4'd1)
			replyByte = boardBytes[3'd7 - byteIdx[2:0]];	// MSB byte first
		else
			replyByte = {result.found, 1'b0, result.cellIdx};	// Status byte
	end

	always_ff @(posedge iCLK or negedge arstN) begin
		if (!arstN) begin
			state <= DecIdle;
			argSel <= ArgBoard;
			argCnt <= '0;
			byteIdx <= '0;
			job <= '0;
			aiReq <= 1'b0;
			txStart <= 1'b0;
			result <= '0;	// Display shows all zeros
		end else begin
			txStart <= issue;
			case (state)
				DecIdle: begin
					if (rxValid) begin
						case (rxData)
							`CMD_BOARD: begin
								argSel <= ArgBoard;
								argCnt <= 3'd7;
								state <= DecArgs;
							end
							`CMD_COLOR: begin
								argSel <= ArgColor;
								argCnt <= 3'd0;
								state <= DecArgs;
							end
							`CMD_MOVES: begin
								argSel <= ArgMoves;
								argCnt <= 3'd1;
								state <= DecArgs;
							end
							`CMD_GO: begin
								aiReq <= 1'b1;	// Job is already stable
								state <= DecWait;
							end
							default: ;	// Unknown byte dropped
						endcase
					end
				end
				DecArgs: begin
					if (rxValid) begin
						case (argSel)
							ArgBoard: job.board <= {job.board[55:0], rxData};
							ArgColor: job.color <= rxData[0];
							default:  job.moveCount <= {job.moveCount[7:0], rxData};
						endcase
						argCnt <= argCnt - 3'd1;
						if (argCnt == 3'd0)
							state <= DecIdle;
					end
				end
				DecWait: begin
					if (aiAck) begin
						result <= aiResult;
						aiReq <= 1'b0;	// Engine drops aiAck next
						byteIdx <= '0;
						state <= DecReply;
					end
				end
				default: begin	// DecReply, rx bytes ignored here
					if (issue)
						byteIdx <= byteIdx + 4'd1;
					else if (!txBusy && !txStart && byteIdx == ReplyEnd)
						state <= DecIdle;	// Last stop bit is out
				end
			endcase
		end
	end

	// Held through the whole txStart cycle
	always_ff @(posedge iCLK) begin
		if (issue)
			txData <= replyByte;
	end

endmodule

//--- hdl/moveSearch.sv
`timescale 1ns/1ps

module moveSearch (
	input  logic                 iCLK,
	input  logic                 arstN,
	input  aiGamePkg::aiJob_t    job,		// Sampled when aiReq is seen
	input  logic                 aiReq,
	output logic                 aiAck,
	output aiGamePkg::aiResult_t result		// Stable while aiAck is high
);
	typedef enum logic [1:0] {SrchIdle, SrchScan, SrchDone} srchState_t;

	srchState_t state;
	logic [63:0] boardQ;	// Working copy of the board
	logic [5:0] cellPtr;	// Cell under test, wraps mod 64
	logic [5:0] stepCnt;	// Cells already examined
	logic dirDown;
	logic loadJob;
	logic cellFree;
	logic scanEnd;

	assign loadJob = (state == SrchIdle) && aiReq;
	assign cellFree = (state == SrchScan) && !boardQ[cellPtr];
	assign scanEnd = (state == SrchScan) && boardQ[cellPtr] && (stepCnt == 6'd63);	// Board full

	always_ff @(posedge iCLK or negedge arstN) begin
		if (!arstN) begin
			state <= SrchIdle;
			cellPtr <= '0;
			stepCnt <= '0;
			dirDown <= 1'b0;
			aiAck <= 1'b0;
		end else begin
			case (state)
				SrchIdle: begin
					if (loadJob) begin
						cellPtr <= job.moveCount[5:0];	// moveCount mod 64
						stepCnt <= '0;
						dirDown <= job.color;
						state <= SrchScan;
					end
				end
				SrchScan: begin
					if (cellFree || scanEnd) begin
						aiAck <= 1'b1;
						state <= SrchDone;
					end else begin
						cellPtr <= dirDown ? cellPtr - 6'd1 : cellPtr + 6'd1;
						stepCnt <= stepCnt + 6'd1;
					end
				end
				default: begin	// SrchDone
					if (!aiReq) begin
						aiAck <= 1'b0;
						state <= SrchIdle;
					end
				end
			endcase
		end
	end

	always_ff @(posedge iCLK) begin
		if (loadJob)
			boardQ <= job.board;
		if (cellFree) begin
			result.board <= boardQ | (64'd1 << cellPtr);	// Claim the cell
			result.found <= 1'b1;
			result.cellIdx <= cellPtr;
		end else if (scanEnd) begin
			result.board <= boardQ;
			result.found <= 1'b0;
			result.cellIdx <= '0;
		end
	end

endmodule

//--- hdl/seg7Bank.sv
`timescale 1ns/1ps

module seg7Bank (
	input  logic [31:0]           value,
	output aiGamePkg::segDigits_t segs	// Active low, digit 7 leftmost
);
	// Segment order gfedcba
	function automatic logic [6:0] hexGlyph(input logic [3:0] nib);
		case (nib)
			4'h0: hexGlyph = 7'b1000000;
			4'h1: hexGlyph = 7'b1111001;
			4'h2: hexGlyph = 7'b0100100;
			4'h3: hexGlyph = 7'b0110000;
			4'h4: hexGlyph = 7'b0011001;
			4'h5: hexGlyph = 7'b0010010;
			4'h6: hexGlyph = 7'b0000010;
			4'h7: hexGlyph = 7'b1111000;
			4'h8: hexGlyph = 7'b0000000;
			4'h9: hexGlyph = 7'b0010000;
			4'hA: hexGlyph = 7'b0001000;
			4'hB: hexGlyph = 7'b0000011;	// Lower case b
			4'hC: hexGlyph = 7'b1000110;
			4'hD: hexGlyph = 7'b0100001;	// Lower case d
			4'hE: hexGlyph = 7'b0000110;
			default: hexGlyph = 7'b0001110;	// F
		endcase
	endfunction

	for (genvar d = 0; d < 8; d++) begin : g_digit
		assign segs[d] = hexGlyph(value[4*d +: 4]);	// Nibble d on digit d
	end

endmodule

//--- hdl/aiGameTop.sv
`timescale 1ns/1ps

module aiGameTop (
	input  logic                  iCLK,
	input  logic                  arstN,
	input  logic                  uartRxd,	// From host
	output logic                  uartTxd,	// To host
	output aiGamePkg::segDigits_t hex,
	output logic [1:0]            ledRed	// [0] engine busy, [1] transmitting
);
	// Serial links
	logic [7:0] rxData;
	logic rxValid;
	logic [7:0] txData;
	logic txStart;
	logic txBusy;
	// Engine handshake
	aiGamePkg::aiJob_t job;
	logic aiReq;
	logic aiAck;
	aiGamePkg::aiResult_t engResult;	// Engine output
	aiGamePkg::aiResult_t dispResult;	// Decoder's captured copy

	uartRx u_rx (
		.iCLK(iCLK), .arstN(arstN),
		.rxd(uartRxd), .rxData(rxData), .rxValid(rxValid)
	);

	uartTx u_tx (
		.iCLK(iCLK), .arstN(arstN),
		.txStart(txStart), .txData(txData), .txd(uartTxd), .txBusy(txBusy)
	);

	cmdDecode u_dec (
		.iCLK(iCLK), .arstN(arstN),
		.rxData(rxData), .rxValid(rxValid),
		.txData(txData), .txStart(txStart), .txBusy(txBusy),
		.job(job), .aiReq(aiReq), .aiAck(aiAck),
		.aiResult(engResult), .result(dispResult)
	);

	moveSearch u_ai (
		.iCLK(iCLK), .arstN(arstN),
		.job(job), .aiReq(aiReq), .aiAck(aiAck), .result(engResult)
	);

	// Low word of the last returned board
	seg7Bank u_seg (
		.value(dispResult.board[31:0]), .segs(hex)
	);

	assign ledRed = {txBusy, aiReq};

endmodule

//--- dv/aiGameTb.sv
`timescale 1ns/1ps
`include "aiGame_defines.svh"

module aiGameTb;
	localparam int Cpb = `CLKS_PER_BIT;
	localparam int MemWords = 256;
	// Active-low gfedcba glyphs for hex 0 to F
	localparam logic [6:0] GlyphTbl [16] = '{
		7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
		7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0E
	};

	logic iCLK = 1'b0;
	logic arstN;
	logic uartRxd;
	logic uartTxd;
	aiGamePkg::segDigits_t hex;
	logic [1:0] ledRed;
	logic [31:0] vecMem [MemWords];	// Flat record stream
	int cycleCnt = 0;
	int cycleLimit = 0;	// Zero until records are counted
	int busyCycles = 0;	// Negedges with ledRed[0] high

	aiGameTop u_dut (
		.iCLK(iCLK), .arstN(arstN), .uartRxd(uartRxd), .uartTxd(uartTxd),
		.hex(hex), .ledRed(ledRed)
	);

	always #4 iCLK = ~iCLK;	// 8 ns period

	always @(posedge iCLK) begin
		cycleCnt <= cycleCnt + 1;
		if (cycleLimit != 0 && cycleCnt > cycleLimit)
			failRun("Timeout: the DUT did not finish its replies within the cycle limit");
	end

	// Engine busy time seen on ledRed[0]
	always @(negedge iCLK) begin
		if (ledRed[0] === 1'b1)
			busyCycles <= busyCycles + 1;
	end

	task automatic failRun(input string why);
		$display("%s", why);
		$display("Simulation failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic checkVal(input string name, input logic [63:0] exp, input logic [63:0] act);
		assert (act === exp)
		else failRun($sformatf("ERR t=%0t %s expected %0h actual %0h", $time, name, exp, act));
	endtask

	function automatic aiGamePkg::segDigits_t expectedSegs(input logic [31:0] word);
		aiGamePkg::segDigits_t s;
		for (int d = 0; d < 8; d++)
			s[d] = GlyphTbl[word[4*d +: 4]];	// Digit d shows nibble d
		return s;
	endfunction

	task automatic checkIdleOutputs();
		checkVal("uartTxd", 1, uartTxd);
		checkVal("ledRed", 0, ledRed);
	endtask

	// Host side 8N1 frame sent LSB first
	task automatic sendByte(input logic [7:0] b);
		logic [9:0] frame;
		frame = {1'b1, b, 1'b0};
		for (int i = 0; i < 10; i++) begin
			@(negedge iCLK);
			uartRxd = frame[i];
			repeat (Cpb - 1) @(negedge iCLK);
		end
	endtask

	task automatic recvByte(output logic [7:0] b);
		@(negedge iCLK);
		while (uartTxd !== 1'b0)
			@(negedge iCLK);
		repeat (Cpb / 2) @(negedge iCLK);	// Middle of start bit
		checkVal("uartTxd start bit", 0, uartTxd);
		checkVal("ledRed[1]", 1, ledRed[1]);	// Transmitter busy over the frame
		for (int i = 0; i < 8; i++) begin
			repeat (Cpb) @(negedge iCLK);
			b[i] = uartTxd;
		end
		repeat (Cpb) @(negedge iCLK);
		checkVal("uartTxd stop bit", 1, uartTxd);
	endtask

	task automatic checkLineQuiet(input int cycles);
		repeat (cycles) begin
			@(negedge iCLK);
			assert (uartTxd === 1'b1)
			else failRun("An extra frame started on uartTxd after a complete reply");
		end
	endtask

	initial begin
		int ptr;
		int nCmd;
		int numRecs;
		int busyBefore;
		logic [7:0] got [`REPLY_BYTES];
		arstN = 1'b0;
		uartRxd = 1'b1;	// Line idle
		for (int i = 0; i < MemWords; i++)
			vecMem[i] = '0;
		$readmemh("dv/aiGame_vectors.txt", vecMem);
		ptr = 0;
		numRecs = 0;
		while (ptr < MemWords && vecMem[ptr] != 0) begin
			numRecs++;
			ptr += vecMem[ptr] + `REPLY_BYTES + 2;	// Count, commands, reply, display
		end
		if (numRecs == 0)
			failRun("The vector file holds no records");
		cycleLimit = 2 * numRecs * (20 * 10 * Cpb + 64) + 16;

		// Outputs checked during the 10 reset cycles and just after
		repeat (10) begin
			@(negedge iCLK);
			checkIdleOutputs();
			checkVal("hex", expectedSegs(32'h0), hex);
		end
		arstN = 1'b1;
		repeat (3) begin
			@(negedge iCLK);
			checkIdleOutputs();
			checkVal("hex", expectedSegs(32'h0), hex);
		end

		ptr = 0;
		for (int rec = 0; rec < numRecs; rec++) begin
			nCmd = vecMem[ptr];
			busyBefore = busyCycles;
			fork
				begin
					for (int i = 1; i <= nCmd; i++)
						sendByte(vecMem[ptr + i][7:0]);
				end
				begin
					for (int j = 0; j < `REPLY_BYTES; j++)
						recvByte(got[j]);
				end
			join
			for (int j = 0; j < `REPLY_BYTES; j++)
				checkVal($sformatf("reply byte %0d of record %0d", j, rec),
					vecMem[ptr + nCmd + 1 + j], got[j]);
			checkVal("hex", expectedSegs(vecMem[ptr + nCmd + 1 + `REPLY_BYTES]), hex);
			assert (busyCycles > busyBefore)
			else failRun($sformatf("ledRed[0] never showed the engine busy in record %0d", rec));
			checkLineQuiet(20 * Cpb);	// Two frame times with no stray reply
			checkIdleOutputs();
			ptr += nCmd + `REPLY_BYTES + 2;
		end
		$display("Simulation completed successfully");
		$finish;
	end

endmodule

//--- src.f
+incdir+include
hdl/aiGamePkg.sv
hdl/uartRx.sv
hdl/uartTx.sv
hdl/cmdDecode.sv
hdl/moveSearch.sv
hdl/seg7Bank.sv
hdl/aiGameTop.sv
dv/aiGameTb.sv

//--- Makefile
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove obj_dir and $(LOG)"

test:
	verilator --binary --timing -Wno-fatal --top-module aiGameTb -f src.f -o aiGameSim
	-./obj_dir/aiGameSim > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Simulation failed" $(LOG); then echo "TEST FAILED"; exit 1; fi
	@if ! grep -q "Simulation completed successfully" $(LOG); then echo "TEST FAILED"; exit 1; fi
	@echo "TEST PASSED"

clean:
	rm -rf obj_dir $(LOG)

//--- dv/aiGame_vectors.txt
// Record: command count N, N command bytes, then nine reply bytes and display word
// Count 00 ends the list; all values hex, reply board MSB byte first, status last
// Colour 0 from cell 3, claims cell 4
0f 42 01 23 45 67 89 ab cd ef 43 00 4d 00 03 47
01 23 45 67 89 ab cd ff 84 89abcdff
// Colour 1 (bit 0 of ff), moves 0x141 so start cell 1, wraps down to cell 63
0f 42 0f 00 00 00 00 00 00 03 43 ff 4d 01 41 47
8f 00 00 00 00 00 00 03 bf 00000003
// Full board, colour and moves kept from the last record
0a 42 ff ff ff ff ff ff ff ff 47
ff ff ff ff ff ff ff ff 00 ffffffff
// Unknown 'X' first, start cell 62 upward wraps to cell 0, second 'G' lands mid reply
11 58 42 c0 00 00 00 00 00 00 00 43 00 4d 00 3e 47 47
c0 00 00 00 00 00 00 01 80 00000001
// End of list
00
